// File: source/fetch_pkg.sv
// shared widths and RV32I opcode values for the fetch front end, referenced by scoped name
package fetch_pkg;

    // datapath widths
    localparam int ADDR_WIDTH = 32;  // byte address of an instruction
    localparam int INST_WIDTH = 32;  // one uncompressed RV32I word

    // opcode field is inst[6:0]
    localparam int OPCODE_WIDTH = 7;

    // control transfer opcodes seen by the predictor
    localparam logic [OPCODE_WIDTH-1:0] OPCODE_BRANCH = 7'b1100011;  // beq/bne/blt/bge/...
    localparam logic [OPCODE_WIDTH-1:0] OPCODE_JAL    = 7'b1101111;  // pc relative jump
    localparam logic [OPCODE_WIDTH-1:0] OPCODE_JALR   = 7'b1100111;  // register jump

    // immediate sizes before sign extension, bit 0 always zero
    localparam int B_IMM_WIDTH = 13;  // +/- 4 KiB
    localparam int J_IMM_WIDTH = 21;  // +/- 1 MiB

    // sequential step, no compressed instructions
    localparam logic [ADDR_WIDTH-1:0] INST_BYTES = 32'd4;

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;  // used by the memory model for faults

    // response channel width
    localparam int RESP_WIDTH = 2;

endpackage

// File: source/fetch_pc_gen.sv
// fetch pc register, loads a redirect, a predicted target or the next sequential word
`timescale 1ns/1ps

module fetch_pc_gen #(
    parameter logic [fetch_pkg::ADDR_WIDTH-1:0] RESET_PC = '0  // first fetch address
) (
    input  logic                            clk,
    input  logic                            reset_i,

    // redirect from execute, wins over everything
    input  logic                            redirect_valid_i,
    input  logic [fetch_pkg::ADDR_WIDTH-1:0] redirect_pc_i,

    // one accepted response per advance
    input  logic                            advance_i,
    input  logic                            pred_taken_i,   // predictor says jump
    input  logic [fetch_pkg::ADDR_WIDTH-1:0] pred_target_i,  // where to jump

    output logic [fetch_pkg::ADDR_WIDTH-1:0] pc_o
);

    logic [fetch_pkg::ADDR_WIDTH-1:0] pc_q;
    logic [fetch_pkg::ADDR_WIDTH-1:0] pc_seq;   // fall through address
    logic [fetch_pkg::ADDR_WIDTH-1:0] pc_next;

    assign pc_seq = pc_q + fetch_pkg::INST_BYTES;

    // priority mux for the next fetch address
    always_comb begin
        pc_next = pc_q;  // hold while a read is outstanding
        if (redirect_valid_i) begin
            pc_next = redirect_pc_i;
        end else if (advance_i) begin
            if (pred_taken_i) begin
                pc_next = pred_target_i;  // backward branch or jal
            end else begin
                pc_next = pc_seq;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q;  // current fetch address, also the pc of the word in flight

endmodule

// File: source/sbpu.sv
// static branch predictor that picks the next fetch pc from the word returned by memory
`timescale 1ns/1ps

module sbpu (
    input  logic [fetch_pkg::INST_WIDTH-1:0] inst_i,        // fetched word or zero on fault
    input  logic                            inst_valid_i,  // word accepted this cycle
    input  logic [fetch_pkg::ADDR_WIDTH-1:0] pc_i,          // address of inst_i

    output logic                            branch_taken_o,   // redirect fetch to branch_addr_o
    output logic [fetch_pkg::ADDR_WIDTH-1:0] branch_addr_o,    // predicted next pc
    output logic                            is_pred_branch_o  // predicted conditional branch
);

    logic [fetch_pkg::OPCODE_WIDTH-1:0] opcode;
    logic                               op_branch;
    logic                               op_jal;
    logic [fetch_pkg::B_IMM_WIDTH-1:0]  b_imm;   // raw B-type offset
    logic [fetch_pkg::J_IMM_WIDTH-1:0]  j_imm;   // raw J-type offset
    logic [fetch_pkg::ADDR_WIDTH-1:0]   b_off;   // sign extended
    logic [fetch_pkg::ADDR_WIDTH-1:0]   j_off;
    logic                               backward;  // negative branch offset
    logic                               taken_branch;
    logic                               taken_jal;

    assign opcode = inst_i[fetch_pkg::OPCODE_WIDTH-1:0];

    assign op_branch = (opcode == fetch_pkg::OPCODE_BRANCH);
    assign op_jal    = (opcode == fetch_pkg::OPCODE_JAL);

    // imm[12|10:5|4:1|11] and imm[20|10:1|11|19:12] with an implicit bit 0
    assign b_imm = {inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign j_imm = {inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    assign b_off = {{(fetch_pkg::ADDR_WIDTH-fetch_pkg::B_IMM_WIDTH){b_imm[12]}}, b_imm};
    assign j_off = {{(fetch_pkg::ADDR_WIDTH-fetch_pkg::J_IMM_WIDTH){j_imm[20]}}, j_imm};

    assign backward = b_imm[fetch_pkg::B_IMM_WIDTH-1];  // sign bit set means loop back

    // backward branches and every jal are taken while jalr never is
    assign taken_branch = inst_valid_i & op_branch & backward;
    assign taken_jal    = inst_valid_i & op_jal;

    assign branch_taken_o   = taken_branch | taken_jal;
    assign is_pred_branch_o = taken_branch;  // execute checks only these

    // target for every opcode and only used when taken
    always_comb begin
        branch_addr_o = pc_i + fetch_pkg::INST_BYTES;  // jalr has no rs1 here and falls through
        if (op_branch) begin
            branch_addr_o = pc_i + b_off;
        end else if (op_jal) begin
            branch_addr_o = pc_i + j_off;
        end
    end

endmodule

// File: source/imem_axil_reader.sv
// AXI4-Lite read master, one word per request at the fetch pc, drops responses made stale by redirect
`timescale 1ns/1ps

module imem_axil_reader (
    input  logic                            clk,
    input  logic                            reset_i,

    input  logic [fetch_pkg::ADDR_WIDTH-1:0] pc_i,             // address to fetch
    input  logic                            redirect_valid_i, // kills the read in flight

    // AR channel
    output logic [fetch_pkg::ADDR_WIDTH-1:0] araddr_o,
    output logic                            arvalid_o,
    input  logic                            arready_i,

    // R channel
    input  logic [fetch_pkg::INST_WIDTH-1:0] rdata_i,
    input  logic [fetch_pkg::RESP_WIDTH-1:0] rresp_i,
    input  logic                            rvalid_i,
    output logic                            rready_o,

    input  logic                            space_i,  // queue can take a word

    // accepted response toward predictor and queue
    output logic                            resp_fire_o,
    output logic [fetch_pkg::INST_WIDTH-1:0] resp_inst_o,
    output logic                            resp_fault_o
);

    typedef enum logic [1:0] {
        ST_IDLE,  // out of reset
        ST_ADDR,  // arvalid up
        ST_DATA   // waiting for rvalid
    } state_t;

    state_t                           state_q;
    logic                             stale_q;  // pending read belongs to an old pc
    logic [fetch_pkg::ADDR_WIDTH-1:0] addr_q;   // address seen on AR last cycle
    logic                             ar_fire;
    logic                             r_fire;

    assign arvalid_o = (state_q == ST_ADDR);
    assign rready_o  = (state_q == ST_DATA) & space_i;  // back-pressure from the queue

    assign ar_fire = arvalid_o & arready_i;
    assign r_fire  = rvalid_i & rready_o;

    // pc only moves on redirect while AR waits, so keep the old address once stale
    assign araddr_o = stale_q ? addr_q : pc_i;

    always_ff @(posedge clk) begin
        if (state_q == ST_ADDR) begin
            addr_q <= araddr_o;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
            stale_q <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    state_q <= ST_ADDR;  // pc already holds the target
                end
                ST_ADDR: begin
                    stale_q <= stale_q | redirect_valid_i;
                    if (ar_fire) begin
                        state_q <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (r_fire) begin
                        state_q <= ST_ADDR;  // next request right away
                        stale_q <= 1'b0;     // old response consumed
                    end else begin
                        stale_q <= stale_q | redirect_valid_i;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                    stale_q <= 1'b0;
                end
            endcase
        end
    end

    // a redirect in the same cycle makes this response stale as well
    assign resp_fire_o = r_fire & ~stale_q & ~redirect_valid_i;

    // SLVERR/DECERR turn into a fault entry with a zero word
    assign resp_fault_o = (rresp_i != fetch_pkg::RESP_OKAY);
    assign resp_inst_o  = resp_fault_o ? '0 : rdata_i;

endmodule

// File: source/fetch_queue.sv
// circular fetch queue between the predictor and decode, flushed on redirect
`timescale 1ns/1ps

module fetch_queue #(
    parameter int QUEUE_DEPTH = 4  // power of two, at least 2
) (
    input  logic                            clk,
    input  logic                            reset_i,
    input  logic                            flush_i,  // drop every entry

    // write side from the reader and predictor
    input  logic                            wr_valid_i,
    input  logic [fetch_pkg::ADDR_WIDTH-1:0] wr_pc_i,
    input  logic [fetch_pkg::INST_WIDTH-1:0] wr_inst_i,
    input  logic                            wr_taken_i,
    input  logic [fetch_pkg::ADDR_WIDTH-1:0] wr_target_i,
    input  logic                            wr_is_branch_i,
    input  logic                            wr_fault_i,
    output logic                            space_o,   // not full

    // read side toward decode
    output logic                            rd_valid_o,
    input  logic                            rd_ready_i,
    output logic [fetch_pkg::ADDR_WIDTH-1:0] rd_pc_o,
    output logic [fetch_pkg::INST_WIDTH-1:0] rd_inst_o,
    output logic                            rd_taken_o,
    output logic [fetch_pkg::ADDR_WIDTH-1:0] rd_target_o,
    output logic                            rd_is_branch_o,
    output logic                            rd_fault_o
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam logic [PTR_W:0] FULL_COUNT = (PTR_W+1)'(QUEUE_DEPTH);

    // entry storage, one array per field
    logic [fetch_pkg::ADDR_WIDTH-1:0] pc_mem     [QUEUE_DEPTH];
    logic [fetch_pkg::INST_WIDTH-1:0] inst_mem   [QUEUE_DEPTH];
    logic                             taken_mem  [QUEUE_DEPTH];
    logic [fetch_pkg::ADDR_WIDTH-1:0] target_mem [QUEUE_DEPTH];
    logic                             branch_mem [QUEUE_DEPTH];
    logic                             fault_mem  [QUEUE_DEPTH];

    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W:0]   count_q;   // one extra bit for full
    logic             do_wr;
    logic             do_rd;

    assign space_o    = (count_q != FULL_COUNT);
    assign rd_valid_o = (count_q != '0);

    assign do_wr = wr_valid_i & space_o;
    assign do_rd = rd_valid_o & rd_ready_i;

    always_ff @(posedge clk) begin
        if (do_wr) begin
            pc_mem[wr_ptr_q]     <= wr_pc_i;
            inst_mem[wr_ptr_q]   <= wr_inst_i;
            taken_mem[wr_ptr_q]  <= wr_taken_i;
            target_mem[wr_ptr_q] <= wr_target_i;
            branch_mem[wr_ptr_q] <= wr_is_branch_i;
            fault_mem[wr_ptr_q]  <= wr_fault_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_wr) wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps, depth is 2^n
            if (do_rd) rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;  // both or neither
            endcase
        end
    end

    // head entry, stable until popped
    assign rd_pc_o        = pc_mem[rd_ptr_q];
    assign rd_inst_o      = inst_mem[rd_ptr_q];
    assign rd_taken_o     = taken_mem[rd_ptr_q];
    assign rd_target_o    = target_mem[rd_ptr_q];
    assign rd_is_branch_o = branch_mem[rd_ptr_q];
    assign rd_fault_o     = fault_mem[rd_ptr_q];

endmodule

// File: source/ifu_top.sv
// instruction fetch unit top, wires pc generator, AXI4-Lite reader, predictor and fetch queue
`timescale 1ns/1ps

module ifu_top #(
    parameter logic [fetch_pkg::ADDR_WIDTH-1:0] RESET_PC    = '0,
    parameter int                               QUEUE_DEPTH = 4
) (
    input  logic                            clk,
    input  logic                            reset_i,

    // AXI4-Lite read master toward instruction memory
    output logic [fetch_pkg::ADDR_WIDTH-1:0] araddr_o,
    output logic                            arvalid_o,
    input  logic                            arready_i,
    input  logic [fetch_pkg::INST_WIDTH-1:0] rdata_i,
    input  logic [fetch_pkg::RESP_WIDTH-1:0] rresp_i,
    input  logic                            rvalid_i,
    output logic                            rready_o,

    // redirect pulse from execute
    input  logic                            redirect_valid_i,
    input  logic [fetch_pkg::ADDR_WIDTH-1:0] redirect_pc_i,

    // decode side
    output logic                            fetch_valid_o,
    input  logic                            fetch_ready_i,
    output logic [fetch_pkg::ADDR_WIDTH-1:0] fetch_pc_o,
    output logic [fetch_pkg::INST_WIDTH-1:0] fetch_inst_o,
    output logic                            fetch_pred_taken_o,
    output logic [fetch_pkg::ADDR_WIDTH-1:0] fetch_pred_target_o,
    output logic                            fetch_is_pred_branch_o,
    output logic                            fetch_fault_o
);

    logic [fetch_pkg::ADDR_WIDTH-1:0] pc;           // current fetch address
    logic                             resp_fire;    // good word this cycle
    logic [fetch_pkg::INST_WIDTH-1:0] resp_inst;
    logic                             resp_fault;
    logic                             pred_taken;
    logic [fetch_pkg::ADDR_WIDTH-1:0] pred_target;
    logic                             is_pred_branch;
    logic                             space;        // queue not full

    fetch_pc_gen #(
        .RESET_PC (RESET_PC)
    ) i_pc_gen (
        .clk              (clk),
        .reset_i          (reset_i),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .advance_i        (resp_fire),     // one step per accepted word
        .pred_taken_i     (pred_taken),
        .pred_target_i    (pred_target),
        .pc_o             (pc)
    );

    imem_axil_reader i_reader (
        .clk              (clk),
        .reset_i          (reset_i),
        .pc_i             (pc),
        .redirect_valid_i (redirect_valid_i),
        .araddr_o         (araddr_o),
        .arvalid_o        (arvalid_o),
        .arready_i        (arready_i),
        .rdata_i          (rdata_i),
        .rresp_i          (rresp_i),
        .rvalid_i         (rvalid_i),
        .rready_o         (rready_o),
        .space_i          (space),
        .resp_fire_o      (resp_fire),
        .resp_inst_o      (resp_inst),
        .resp_fault_o     (resp_fault)
    );

    // same cycle decision on the arriving word
    sbpu i_sbpu (
        .inst_i           (resp_inst),
        .inst_valid_i     (resp_fire),
        .pc_i             (pc),
        .branch_taken_o   (pred_taken),
        .branch_addr_o    (pred_target),
        .is_pred_branch_o (is_pred_branch)
    );

    fetch_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) i_queue (
        .clk            (clk),
        .reset_i        (reset_i),
        .flush_i        (redirect_valid_i),  // wrong path entries go away
        .wr_valid_i     (resp_fire),
        .wr_pc_i        (pc),
        .wr_inst_i      (resp_inst),
        .wr_taken_i     (pred_taken),
        .wr_target_i    (pred_target),
        .wr_is_branch_i (is_pred_branch),
        .wr_fault_i     (resp_fault),
        .space_o        (space),
        .rd_valid_o     (fetch_valid_o),
        .rd_ready_i     (fetch_ready_i),
        .rd_pc_o        (fetch_pc_o),
        .rd_inst_o      (fetch_inst_o),
        .rd_taken_o     (fetch_pred_taken_o),
        .rd_target_o    (fetch_pred_target_o),
        .rd_is_branch_o (fetch_is_pred_branch_o),
        .rd_fault_o     (fetch_fault_o)
    );

endmodule

// File: testbench/tb_clock.sv
// testbench clock and reset source, 100 ns period with reset held for the first cycles
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 100,  // full clock period
    parameter int RESET_CYCLES = 5     // rising edges with reset high
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // synchronous release on a rising edge
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_o <= 1'b0;
    end

endmodule

// File: testbench/imem_axil_model.sv
// AXI4-Lite read slave for the testbench, program memory with random delays and one faulting word
`timescale 1ns/1ps

module imem_axil_model #(
    parameter int          MEM_WORDS  = 256,       // power of two
    parameter logic [31:0] FAULT_ADDR = 32'h138    // answers SLVERR here
) (
    input  logic        clk,
    input  logic        reset_i,

    input  logic [31:0] araddr_i,
    input  logic        arvalid_i,
    output logic        arready_o,

    output logic [31:0] rdata_o,
    output logic [1:0]  rresp_o,
    output logic        rvalid_o,
    input  logic        rready_i
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [31:0] mem [MEM_WORDS];  // filled by the testbench before reset ends
    logic        busy_q;           // read accepted, response not done yet
    logic [31:0] addr_q;
    logic [1:0]  delay_q;          // cycles left before rvalid

    always @(posedge clk) begin
        if (reset_i) begin
            arready_o <= 1'b0;
            rvalid_o  <= 1'b0;
            rdata_o   <= '0;
            rresp_o   <= fetch_pkg::RESP_OKAY;
            busy_q    <= 1'b0;
            addr_q    <= '0;
            delay_q   <= '0;
        end else if (!busy_q) begin
            if (arvalid_i && arready_o) begin
                busy_q    <= 1'b1;
                addr_q    <= araddr_i;
                delay_q   <= 2'($urandom_range(3, 0));
                arready_o <= 1'b0;
            end else begin
                arready_o <= 1'($urandom_range(1, 0));  // random AR stall
            end
        end else if (!rvalid_o) begin
            if (delay_q == 2'd0) begin
                rvalid_o <= 1'b1;
                rdata_o  <= mem[addr_q[IDX_W+1:2]];  // word index, low bits ignored
                if (addr_q == FAULT_ADDR) begin
                    rresp_o <= fetch_pkg::RESP_SLVERR;
                end else begin
                    rresp_o <= fetch_pkg::RESP_OKAY;
                end
            end else begin
                delay_q <= delay_q - 2'd1;
            end
        end else if (rready_i) begin
            rvalid_o <= 1'b0;  // response taken
            busy_q   <= 1'b0;
        end
    end

endmodule

// File: testbench/tb_ifu.sv
// testbench top for the fetch unit that runs a fixed program and checks every entry against a walker
`timescale 1ns/1ps

module tb_ifu;

    localparam logic [31:0] RESET_PC    = 32'h100;
    localparam int          QUEUE_DEPTH = 2;        // small enough for back-pressure to reach AXI
    localparam logic [31:0] FAULT_ADDR  = 32'h138;
    localparam int          MEM_WORDS   = 256;      // addresses 0x000..0x3fc
    localparam int          ROUNDS      = 6;        // redirects issued
    localparam int          PER_ROUND   = 40;       // entries between redirects
    localparam int          IDLE_LIMIT  = 400;      // cycles without an entry

    logic        clk;
    logic        reset_i;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic        redirect_valid = 1'b0;
    logic [31:0] redirect_pc    = '0;
    logic        fetch_valid;
    logic        fetch_ready    = 1'b0;
    logic [31:0] fetch_pc;
    logic [31:0] fetch_inst;
    logic        fetch_taken;
    logic [31:0] fetch_target;
    logic        fetch_branch;
    logic        fetch_fault;
    logic        quiet = 1'b0;  // forces ready low around a redirect

    // reference state
    logic [31:0] prog [MEM_WORDS];
    logic [31:0] exp_pc;
    logic [31:0] exp_inst;
    logic        exp_fault;
    logic [6:0]  exp_opcode;
    logic [31:0] b_ofs;
    logic [31:0] j_ofs;
    logic        exp_branch;
    logic        exp_taken;
    logic [31:0] exp_target;
    int          accepted   = 0;
    int          seen_fault = 0;
    int          seen_back  = 0;
    int          seen_jal   = 0;

    tb_clock i_clock (
        .clk_o   (clk),
        .reset_o (reset_i)
    );

    imem_axil_model #(
        .MEM_WORDS  (MEM_WORDS),
        .FAULT_ADDR (FAULT_ADDR)
    ) i_mem (
        .clk       (clk),
        .reset_i   (reset_i),
        .araddr_i  (araddr),
        .arvalid_i (arvalid),
        .arready_o (arready),
        .rdata_o   (rdata),
        .rresp_o   (rresp),
        .rvalid_o  (rvalid),
        .rready_i  (rready)
    );

    ifu_top #(
        .RESET_PC    (RESET_PC),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) i_dut (
        .clk                    (clk),
        .reset_i                (reset_i),
        .araddr_o               (araddr),
        .arvalid_o              (arvalid),
        .arready_i              (arready),
        .rdata_i                (rdata),
        .rresp_i                (rresp),
        .rvalid_i               (rvalid),
        .rready_o               (rready),
        .redirect_valid_i       (redirect_valid),
        .redirect_pc_i          (redirect_pc),
        .fetch_valid_o          (fetch_valid),
        .fetch_ready_i          (fetch_ready),
        .fetch_pc_o             (fetch_pc),
        .fetch_inst_o           (fetch_inst),
        .fetch_pred_taken_o     (fetch_taken),
        .fetch_pred_target_o    (fetch_target),
        .fetch_is_pred_branch_o (fetch_branch),
        .fetch_fault_o          (fetch_fault)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    // B-type layout imm[12|10:5] rs2 rs1 funct3 imm[4:1|11] opcode
    function automatic logic [31:0] enc_branch(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], fetch_pkg::OPCODE_BRANCH};
    endfunction

    // J-type layout imm[20|10:1|11|19:12] rd opcode
    function automatic logic [31:0] enc_jal(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, fetch_pkg::OPCODE_JAL};
    endfunction

    function automatic logic [31:0] enc_jalr();
        return {12'h000, 5'd1, 3'b000, 5'd0, fetch_pkg::OPCODE_JALR};  // jalr x0, 0(x1)
    endfunction

    task automatic load_program();
        logic [31:0] addr;
        for (int i = 0; i < MEM_WORDS; i++) begin
            addr = 32'(i) << 2;
            prog[i] = {addr[24:0], 7'b0010011};  // op-imm word whose upper bits carry the address
        end
        prog[32'h108 >> 2] = enc_branch(13'h0008, 3'b000);  // beq forward +8
        prog[32'h110 >> 2] = enc_jalr();
        prog[32'h114 >> 2] = enc_jal(21'h000020);           // to 0x134
        prog[32'h140 >> 2] = enc_branch(13'h1ff0, 3'b001);  // bne back -16 closes loop 0x130..0x140
        prog[32'h220 >> 2] = enc_jal(21'h1ffee0);           // jal -0x120 back to 0x100
        for (int i = 0; i < MEM_WORDS; i++) begin
            i_mem.mem[i] = prog[i];
        end
    endtask

    // expected entry at exp_pc decoded straight from the ISA fields
    always_comb begin
        exp_fault  = (exp_pc == FAULT_ADDR);
        exp_inst   = exp_fault ? 32'h0 : prog[exp_pc[9:2]];  // 256 words
        exp_opcode = exp_inst[6:0];
        b_ofs = {{19{exp_inst[31]}}, exp_inst[31], exp_inst[7], exp_inst[30:25],
                 exp_inst[11:8], 1'b0};
        j_ofs = {{11{exp_inst[31]}}, exp_inst[31], exp_inst[19:12], exp_inst[20],
                 exp_inst[30:21], 1'b0};
        exp_branch = (exp_opcode == fetch_pkg::OPCODE_BRANCH) && b_ofs[31];  // backward only
        exp_taken  = exp_branch || (exp_opcode == fetch_pkg::OPCODE_JAL);
        if (exp_opcode == fetch_pkg::OPCODE_BRANCH) begin
            exp_target = exp_pc + b_ofs;
        end else if (exp_opcode == fetch_pkg::OPCODE_JAL) begin
            exp_target = exp_pc + j_ofs;
        end else begin
            exp_target = exp_pc + 32'd4;  // jalr and the rest
        end
    end

    // walker steps on each accepted entry
    always @(posedge clk) begin
        if (reset_i) begin
            exp_pc <= RESET_PC;
        end else if (redirect_valid) begin
            exp_pc <= redirect_pc;
        end else if (fetch_valid && fetch_ready) begin
            exp_pc   <= exp_taken ? exp_target : exp_pc + 32'd4;
            accepted <= accepted + 1;
            if (exp_fault) seen_fault <= seen_fault + 1;
            if (exp_branch) seen_back <= seen_back + 1;
            if (exp_opcode == fetch_pkg::OPCODE_JAL) seen_jal <= seen_jal + 1;
        end
    end

    // random decode ready unless a redirect is being sent
    always @(posedge clk) begin
        if (reset_i) begin
            fetch_ready <= 1'b0;
        end else begin
            fetch_ready <= quiet ? 1'b0 : ($urandom_range(3, 0) != 0);
        end
    end

    check_pc: assert property (@(posedge clk) disable iff (reset_i)
        (fetch_valid && fetch_ready) |-> (fetch_pc == exp_pc))
        else report_failure($sformatf("Mismatch fetch_pc_o: got %h expected %h",
                                      $sampled(fetch_pc), $sampled(exp_pc)));

    check_inst: assert property (@(posedge clk) disable iff (reset_i)
        (fetch_valid && fetch_ready) |-> (fetch_inst == exp_inst))
        else report_failure($sformatf("Mismatch fetch_inst_o: got %h expected %h",
                                      $sampled(fetch_inst), $sampled(exp_inst)));

    check_taken: assert property (@(posedge clk) disable iff (reset_i)
        (fetch_valid && fetch_ready) |-> (fetch_taken == exp_taken))
        else report_failure($sformatf("Mismatch fetch_pred_taken_o: got %h expected %h",
                                      $sampled(fetch_taken), $sampled(exp_taken)));

    check_target: assert property (@(posedge clk) disable iff (reset_i)
        (fetch_valid && fetch_ready) |-> (fetch_target == exp_target))
        else report_failure($sformatf("Mismatch fetch_pred_target_o: got %h expected %h",
                                      $sampled(fetch_target), $sampled(exp_target)));

    check_branch: assert property (@(posedge clk) disable iff (reset_i)
        (fetch_valid && fetch_ready) |-> (fetch_branch == exp_branch))
        else report_failure($sformatf("Mismatch fetch_is_pred_branch_o: got %h expected %h",
                                      $sampled(fetch_branch), $sampled(exp_branch)));

    check_fault: assert property (@(posedge clk) disable iff (reset_i)
        (fetch_valid && fetch_ready) |-> (fetch_fault == exp_fault))
        else report_failure($sformatf("Mismatch fetch_fault_o: got %h expected %h",
                                      $sampled(fetch_fault), $sampled(exp_fault)));

    // stalled entry must not move or vanish unless flushed
    check_hold: assert property (@(posedge clk) disable iff (reset_i)
        (fetch_valid && !fetch_ready && !redirect_valid) |=>
            (fetch_valid && $stable(fetch_pc) && $stable(fetch_inst) && $stable(fetch_taken)
             && $stable(fetch_target) && $stable(fetch_branch) && $stable(fetch_fault)))
        else report_failure("stalled fetch entry changed or dropped while ready was low");

    // waiting AR request keeps valid and address until accepted
    check_ar_hold: assert property (@(posedge clk) disable iff (reset_i)
        (arvalid && !arready) |=> (arvalid && $stable(araddr)))
        else report_failure("AR request dropped or changed its address before the handshake");

    task automatic wait_reset();
        int cycles;
        cycles = 0;
        while (reset_i) begin
            @(posedge clk);
            cycles++;
            if (cycles > 20) report_failure("timeout: reset never released");
        end
    endtask

    task automatic wait_entries(input int target);
        int idle;
        int last;
        idle = 0;
        last = accepted;
        while (accepted < target) begin
            @(posedge clk);
            if (accepted != last) begin
                last = accepted;
                idle = 0;
            end else begin
                idle++;
            end
            if (idle > IDLE_LIMIT) report_failure("timeout: no fetch entry arrived");
        end
    endtask

    // ready drops one edge ahead so no entry is taken in the flush cycle
    task automatic issue_redirect(input logic [31:0] pc);
        @(posedge clk);
        quiet <= 1'b1;
        @(posedge clk);
        redirect_valid <= 1'b1;
        redirect_pc    <= pc;
        @(posedge clk);
        redirect_valid <= 1'b0;
        quiet          <= 1'b0;
    endtask

    initial begin
        void'($urandom(32'hfe36_7842));
        load_program();
        wait_reset();
        for (int r = 0; r < ROUNDS; r++) begin
            wait_entries(accepted + PER_ROUND);
            issue_redirect(r[0] ? 32'h180 : 32'h200);  // alternate targets
        end
        wait_entries(accepted + PER_ROUND);
        if (seen_fault == 0 || seen_back == 0 || seen_jal == 0) begin
            report_failure("program never reached the fault, loop branch or jal entries");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

// File: all.f
source/fetch_pkg.sv
source/fetch_pc_gen.sv
source/sbpu.sv
source/imem_axil_reader.sv
source/fetch_queue.sv
source/ifu_top.sv
testbench/tb_clock.sv
testbench/imem_axil_model.sv
testbench/tb_ifu.sv

// File: Makefile
TOP := tb_ifu

.PHONY: sim clean

sim:
	verilator --binary --assert --timing --top-module $(TOP) -f all.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf obj_dir
